// ==== tcb_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// TCB protocol definitions
// bus widths, transfer size encoding and response delay
//////////////////////////////////////////////////////////////////////

`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // data bus width in bits
  localparam int unsigned tcb_data_w = 32;
  // byte address width, covers 1 KiB
  localparam int unsigned tcb_adr_w = 10;

  // fixed delay from transfer edge to response
  localparam int unsigned tcb_dly = 1;

  //////////////////////////////////////////////////////////////////////
  // transfer size
  //////////////////////////////////////////////////////////////////////

  // transfer carries 2**siz bytes
  typedef enum logic [1:0] {
    siz_byte = 2'd0,
    siz_half = 2'd1,
    siz_word = 2'd2
  } tcb_siz_t;

endpackage : tcb_pkg

`default_nettype wire

// ==== mem_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// memory geometry
// word count, word address width and byte lanes per word
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mem_pkg;

  // number of 32-bit words in the array
  localparam int unsigned mem_words = 256;

  // word address width
  localparam int unsigned mem_wadr_w = $clog2(mem_words);

  // byte lanes per word
  localparam int unsigned mem_ben_w = 4;

endpackage : mem_pkg

`default_nettype wire

// ==== tcb_req_decode.sv ====
//////////////////////////////////////////////////////////////////////
// TCB request decoder
// maps size and byte address onto word address, byte enables
// and lane-shifted write data, flags misaligned requests
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tcb_req_decode (
  input  logic                           vld,
  input  logic                           wen,
  input  logic [tcb_pkg::tcb_adr_w-1:0]  adr,
  input  tcb_pkg::tcb_siz_t              siz,
  input  logic [tcb_pkg::tcb_data_w-1:0] wdt,
  output logic                           req_vld,
  output logic                           req_wen,
  output logic [mem_pkg::mem_wadr_w-1:0] wadr,
  output logic [mem_pkg::mem_ben_w-1:0]  ben,
  output logic [tcb_pkg::tcb_data_w-1:0] mem_wdt,
  output logic [1:0]                     ofs,
  output logic                           mis
);

  import tcb_pkg::*;
  import mem_pkg::*;

  // lanes covered by the size, before the offset shift
  logic [mem_ben_w-1:0] siz_msk;

  // transfer control passes straight on
  assign req_vld = vld;
  assign req_wen = wen;

  // byte offset inside the word, and word index
  assign ofs  = adr[1:0];
  assign wadr = adr[tcb_adr_w-1:2];

  // size mask and alignment check
  always_comb begin
    case (siz)
      siz_byte: begin
        siz_msk = 4'b0001;
        mis     = 1'b0;
      end
      siz_half: begin
        siz_msk = 4'b0011;
        mis     = ofs[0];
      end
      // word, and the unused code treated alike
      default: begin
        siz_msk = 4'b1111;
        mis     = |ofs;
      end
    endcase
  end

  // misaligned request enables nothing
  assign ben = mis ? '0 : siz_msk << ofs;

  // low lanes move up by offset bytes
  assign mem_wdt = wdt << {ofs, 3'b000};

endmodule : tcb_req_decode

`default_nettype wire

// ==== tcb_mem.sv ====
//////////////////////////////////////////////////////////////////////
// TCB word memory
// byte-enabled writes, reads through a fixed delay pipeline
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tcb_mem (
  input  logic                           tcb,
  input  logic                           rst_n,
  input  logic                           req_vld,
  input  logic                           req_wen,
  input  logic [mem_pkg::mem_wadr_w-1:0] wadr,
  input  logic [mem_pkg::mem_ben_w-1:0]  ben,
  input  logic [tcb_pkg::tcb_data_w-1:0] wdt,
  output logic [tcb_pkg::tcb_data_w-1:0] rdt
);

  import tcb_pkg::*;
  import mem_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  logic [tcb_data_w-1:0] mem [0:mem_words-1];

  // enabled lanes of the addressed word
  logic [tcb_data_w-1:0] rd_word;

  // read pipeline, last stage drives rdt
  logic [tcb_data_w-1:0] rdt_q [tcb_dly];

  // write commits at the transfer edge
  always_ff @(posedge tcb) begin
    if (req_vld && req_wen) begin
      for (int b = 0; b < mem_ben_w; b++) begin
        if (ben[b]) begin
          mem[wadr][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  // disabled lanes read as zero
  always_comb begin
    for (int b = 0; b < mem_ben_w; b++) begin
      rd_word[8*b +: 8] = ben[b] ? mem[wadr][8*b +: 8] : 8'h00;
    end
  end

  // first stage loads on a read transfer, later stages shift
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      for (int d = 0; d < tcb_dly; d++) begin
        rdt_q[d] <= '0;
      end
    end else begin
      if (req_vld && !req_wen) begin
        rdt_q[0] <= rd_word;
      end
      for (int d = 1; d < tcb_dly; d++) begin
        rdt_q[d] <= rdt_q[d-1];
      end
    end
  end

  assign rdt = rdt_q[tcb_dly-1];

endmodule : tcb_mem

`default_nettype wire

// ==== tcb_rsp_align.sv ====
//////////////////////////////////////////////////////////////////////
// TCB response aligner
// delays request attributes alongside the memory, then moves
// read data to the low lanes and reports misalignment
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tcb_rsp_align (
  input  logic                           tcb,
  input  logic                           rst_n,
  input  logic                           req_vld,
  input  logic                           req_wen,
  input  logic [1:0]                     ofs,
  input  tcb_pkg::tcb_siz_t              siz,
  input  logic                           mis,
  input  logic [tcb_pkg::tcb_data_w-1:0] mem_rdt,
  output logic                           rsp_vld,
  output logic [tcb_pkg::tcb_data_w-1:0] rdt,
  output logic                           err
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // attribute pipeline
  //////////////////////////////////////////////////////////////////////

  // control stages
  logic     vld_q [tcb_dly];
  logic     ren_q [tcb_dly];
  logic     mis_q [tcb_dly];
  // payload stages
  logic [1:0] ofs_q [tcb_dly];
  tcb_siz_t   siz_q [tcb_dly];

  // byte mask of the response size
  logic [tcb_data_w-1:0] siz_msk;

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      for (int d = 0; d < tcb_dly; d++) begin
        vld_q[d] <= 1'b0;
        ren_q[d] <= 1'b0;
        mis_q[d] <= 1'b0;
      end
    end else begin
      vld_q[0] <= req_vld;
      // only aligned reads return data
      ren_q[0] <= req_vld & ~req_wen & ~mis;
      mis_q[0] <= req_vld & mis;
      for (int d = 1; d < tcb_dly; d++) begin
        vld_q[d] <= vld_q[d-1];
        ren_q[d] <= ren_q[d-1];
        mis_q[d] <= mis_q[d-1];
      end
    end
  end

  // offset and size follow without reset
  always_ff @(posedge tcb) begin
    ofs_q[0] <= ofs;
    siz_q[0] <= siz;
    for (int d = 1; d < tcb_dly; d++) begin
      ofs_q[d] <= ofs_q[d-1];
      siz_q[d] <= siz_q[d-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  assign rsp_vld = vld_q[tcb_dly-1];
  assign err     = mis_q[tcb_dly-1];

  always_comb begin
    case (siz_q[tcb_dly-1])
      siz_byte: siz_msk = 32'h0000_00ff;
      siz_half: siz_msk = 32'h0000_ffff;
      default:  siz_msk = 32'hffff_ffff;
    endcase
  end

  // shift down by offset bytes, clear above the size
  assign rdt = ren_q[tcb_dly-1]
             ? (mem_rdt >> {ofs_q[tcb_dly-1], 3'b000}) & siz_msk
             : '0;

endmodule : tcb_rsp_align

`default_nettype wire

// ==== tcb_mem_sys.sv ====
//////////////////////////////////////////////////////////////////////
// TCB memory subsystem
// request decoder, word memory and response aligner
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tcb_mem_sys (
  input  logic                           tcb,
  input  logic                           rst_n,
  input  logic                           vld,
  input  logic                           wen,
  input  logic [tcb_pkg::tcb_adr_w-1:0]  adr,
  input  tcb_pkg::tcb_siz_t              siz,
  input  logic [tcb_pkg::tcb_data_w-1:0] wdt,
  output logic                           rsp_vld,
  output logic [tcb_pkg::tcb_data_w-1:0] rdt,
  output logic                           err
);

  import tcb_pkg::*;
  import mem_pkg::*;

  // memory-mode request
  logic                  req_vld;
  logic                  req_wen;
  logic [mem_wadr_w-1:0] wadr;
  logic [mem_ben_w-1:0]  ben;
  logic [tcb_data_w-1:0] mem_wdt;
  // attributes for the aligner
  logic [1:0]            ofs;
  logic                  mis;
  // full word from memory
  logic [tcb_data_w-1:0] mem_rdt;

  tcb_req_decode tcb_req_decode_i (
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .req_vld (req_vld),
    .req_wen (req_wen),
    .wadr    (wadr),
    .ben     (ben),
    .mem_wdt (mem_wdt),
    .ofs     (ofs),
    .mis     (mis)
  );

  tcb_mem tcb_mem_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_wen (req_wen),
    .wadr    (wadr),
    .ben     (ben),
    .wdt     (mem_wdt),
    .rdt     (mem_rdt)
  );

  tcb_rsp_align tcb_rsp_align_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_wen (req_wen),
    .ofs     (ofs),
    .siz     (siz),
    .mis     (mis),
    .mem_rdt (mem_rdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .err     (err)
  );

endmodule : tcb_mem_sys

`default_nettype wire

// ==== tb_tcb_mem_sys.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the TCB memory subsystem
// byte-array model, reference response function, in-order compare
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_tcb_mem_sys;

  timeunit 1ns;
  timeprecision 100ps;

  import tcb_pkg::*;

  // clock, reset and manager side
  logic                  tcb = 1'b0;
  logic                  rst_n;
  logic                  vld;
  logic                  wen;
  logic [tcb_adr_w-1:0]  adr;
  tcb_siz_t              siz;
  logic [tcb_data_w-1:0] wdt;
  // responses
  logic                  rsp_vld;
  logic [tcb_data_w-1:0] rdt;
  logic                  err;

  // byte model of the whole address space
  logic [7:0] model [0:(1<<tcb_adr_w)-1];
  // expectations in request order
  logic [31:0] exp_rdt_q [$];
  logic        exp_err_q [$];
  int          exp_cyc_q [$];

  int     cyc    = 0;
  int     checks = 0;
  int     errors = 0;
  logic   armed  = 1'b0;
  integer seed   = 14283;

  always #2 tcb = ~tcb;

  tcb_mem_sys tcb_mem_sys_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .err     (err)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // expected {err, rdt} of a request from the byte model
  function automatic logic [32:0] ref_rsp(input logic [tcb_adr_w-1:0] a,
                                          input tcb_siz_t s, input logic w);
    int          nb;
    logic [31:0] d;
    logic        bad;
    nb  = 1 << int'(s);
    // offset must be a multiple of the size
    bad = (int'(a) % nb) != 0;
    d   = '0;
    if (!w && !bad) begin
      for (int i = 0; i < nb; i++) begin
        d[8*i +: 8] = model[int'(a) + i];
      end
    end
    return {bad, d};
  endfunction

  // store the low bytes of an aligned write
  task automatic model_write(input logic [tcb_adr_w-1:0] a, input tcb_siz_t s,
                             input logic [31:0] d);
    int nb;
    nb = 1 << int'(s);
    if ((int'(a) % nb) == 0) begin
      for (int i = 0; i < nb; i++) begin
        model[int'(a) + i] = d[8*i +: 8];
      end
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  // record each transfer at the rising edge
  always @(posedge tcb) begin : monitor
    logic [32:0] rsp;
    cyc   = cyc + 1;
    armed = rst_n;
    if (rst_n && vld) begin
      rsp = ref_rsp(adr, siz, wen);
      exp_rdt_q.push_back(rsp[31:0]);
      exp_err_q.push_back(rsp[32]);
      exp_cyc_q.push_back(cyc);
      if (wen) begin
        model_write(adr, siz, wdt);
      end
    end
  end

  // compare responses at the falling edge
  always @(negedge tcb) begin
    if (armed) begin
      if (rsp_vld === 1'b1) begin
        if (exp_rdt_q.size() == 0) begin
          errors++;
          $display("response at cycle %0d with no request outstanding", cyc);
        end else begin
          check("rdt", rdt, exp_rdt_q.pop_front());
          check("err", 32'(err), 32'(exp_err_q.pop_front()));
          check("rsp_cycle", cyc, exp_cyc_q.pop_front() + tcb_dly - 1);
        end
      end else begin
        check("rsp_vld", 32'(rsp_vld), 32'd0);
        check("err", 32'(err), 32'd0);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic send(input logic w, input logic [tcb_adr_w-1:0] a, input tcb_siz_t s,
                      input logic [31:0] d);
    @(negedge tcb);
    vld = 1'b1;
    wen = w;
    adr = a;
    siz = s;
    wdt = d;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge tcb);
      vld = 1'b0;
      wen = 1'b0;
    end
  endtask

  // bus idle until every response is back
  task automatic wait_drain();
    int t;
    t = 0;
    idle(1);
    while (exp_rdt_q.size() != 0 && t < 20) begin
      @(posedge tcb);
      t++;
    end
    if (exp_rdt_q.size() != 0) begin
      errors++;
      $display("timeout with %0d responses still outstanding", exp_rdt_q.size());
    end
  endtask

  initial begin
    logic [31:0]          r;
    logic [tcb_adr_w-1:0] a;
    tcb_siz_t             s;
    rst_n = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    siz   = siz_byte;
    wdt   = '0;
    repeat (3) @(negedge tcb);
    rst_n = 1'b1;
    // quiet bus after reset
    idle(4);
    // fill every word with an address-dependent pattern
    for (int w = 0; w < 256; w++) begin
      send(1'b1, 10'(w * 4), siz_word, 32'(w) * 32'h9e37_79b9 + 32'h0102_0304);
    end
    for (int w = 0; w < 256; w++) begin
      send(1'b0, 10'(w * 4), siz_word, '0);
    end
    wait_drain();
    // byte and halfword writes merge into one word
    // junk in the unused upper data bytes
    send(1'b1, 10'h040, siz_byte, 32'hdead_be11);
    send(1'b1, 10'h042, siz_half, 32'h5555_beef);
    send(1'b1, 10'h041, siz_byte, 32'hffff_ff7e);
    send(1'b0, 10'h040, siz_word, '0);
    wait_drain();
    // sub-word reads at every legal offset
    for (int i = 0; i < 3; i++) begin
      a = (i == 0) ? 10'h040 : (i == 1) ? 10'h100 : 10'h3fc;
      for (int o = 0; o < 4; o++) begin
        send(1'b0, a + 10'(o), siz_byte, '0);
      end
      send(1'b0, a, siz_half, '0);
      send(1'b0, a + 10'd2, siz_half, '0);
    end
    wait_drain();
    // misaligned reads and writes followed by aligned readback
    send(1'b0, 10'h051, siz_half, '0);
    send(1'b1, 10'h053, siz_half, 32'h0000_aaaa);
    send(1'b1, 10'h061, siz_word, 32'h1234_5678);
    send(1'b0, 10'h062, siz_word, '0);
    send(1'b1, 10'h063, siz_word, 32'h8765_4321);
    send(1'b0, 10'h050, siz_word, '0);
    send(1'b0, 10'h060, siz_word, '0);
    wait_drain();
    // random back-to-back traffic with mostly aligned addresses
    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      s = tcb_siz_t'(2'($unsigned($random(seed)) % 3));
      a = r[tcb_adr_w-1:0];
      if (r[31:30] != 2'b00) begin
        a = a & ~10'((1 << int'(s)) - 1);
      end
      send(r[29], a, s, $random(seed));
    end
    wait_drain();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_tcb_mem_sys

`default_nettype wire

// ==== filelist.f ====
tcb_pkg.sv
mem_pkg.sv
tcb_req_decode.sv
tcb_mem.sv
tcb_rsp_align.sv
tcb_mem_sys.sv
tb_tcb_mem_sys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the TCB memory testbench with Verilator
verilator --binary --timing --top-module tb_tcb_mem_sys -f filelist.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
